// ==== flist.f ====
+incdir+.
div_pkg.sv
int_div_dpath.sv
int_div_ctrl.sv
int_div_iterative.sv
tb_int_div_iterative.sv

// ==== Bender.yml ====
package:
  name: int_div_iterative

sources:
  - include_dirs:
      - .
    files:
      - div_pkg.sv
      - int_div_dpath.sv
      - int_div_ctrl.sv
      - int_div_iterative.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_int_div_iterative.sv

// ==== tb_int_div_iterative.sv ====
// testbench for the iterative integer divider
// directed and seeded random divisions checked against a reference model
`default_nettype none

`include "div_consts.svh"

module tb_int_div_iterative;

  localparam int W = `DIV_DATA_W;

  // total requests over all tests sets the watchdog time
  localparam int NUM_REQS = 56;

  // accept edge is edge zero and the response is sampled one edge after the last step
  localparam int LATENCY = `DIV_ITERS + 1;

  // bound for any single wait loop
  localparam int MAX_WAIT = 4 * `DIV_ITERS;

  logic                 clk;
  logic                 reset;
  div_pkg::div_fn_e     req_fn;
  logic [W-1:0]         req_a;
  logic [W-1:0]         req_b;
  logic                 req_val;
  logic                 req_rdy;
  div_pkg::div_result_t resp_result;
  logic                 resp_val;
  logic                 resp_rdy;

  int_div_iterative i_int_div_iterative (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  always #2 clk = ~clk;

  // --------------------------------------------------
  // reference model and compare tasks
  // --------------------------------------------------

  // divide magnitudes and then fix signs
  function automatic div_pkg::div_result_t expected_div(
    input div_pkg::div_fn_e fn,
    input logic [W-1:0]     a,
    input logic [W-1:0]     b
  );
    logic                 neg_a;
    logic                 neg_b;
    logic [W-1:0]         ma;
    logic [W-1:0]         mb;
    logic [W-1:0]         q;
    logic [W-1:0]         r;
    div_pkg::div_result_t res;
    neg_a = (fn == div_pkg::DIV_FN_SIGNED) && a[W-1];
    neg_b = (fn == div_pkg::DIV_FN_SIGNED) && b[W-1];
    ma = neg_a ? -a : a;
    mb = neg_b ? -b : b;
    // divide by zero gives an all-ones quotient and the dividend magnitude as remainder
    if (mb == '0) begin
      q = '1;
      r = ma;
    end else begin
      q = ma / mb;
      r = ma % mb;
    end
    if (neg_a ^ neg_b) begin
      q = -q;
    end
    // remainder takes the dividend's sign
    if (neg_a) begin
      r = -r;
    end
    res.rem  = r;
    res.quot = q;
    return res;
  endfunction

  task automatic check_result(input string name, input div_pkg::div_result_t exp,
                              input div_pkg::div_result_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      $display("TB FAILED");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      $display("TB FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
      $display("TB FAILED");
      $fatal(1, "latency mismatch");
    end
  endtask

  task automatic abort_on_hang(input string what);
    $display("the divider never %s", what);
    $display("TB FAILED");
    $fatal(1, "handshake hang");
  endtask

  // --------------------------------------------------
  // handshake helpers called 1 unit after an edge
  // --------------------------------------------------

  task automatic drive_request(input div_pkg::div_fn_e fn, input logic [W-1:0] a,
                               input logic [W-1:0] b);
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
  endtask

  // returns the number of edges spent with req_rdy low
  task automatic wait_accept(output int waits);
    waits = 0;
    while (!req_rdy) begin
      @(posedge clk);
      #1;
      waits++;
      if (waits > MAX_WAIT) begin
        abort_on_hang("accepted a request");
      end
    end
    // this edge is the transfer
    @(posedge clk);
    #1;
    req_val = 1'b0;
  endtask

  task automatic wait_response(input string name, output div_pkg::div_result_t res);
    int edges;
    edges = 0;
    while (!resp_val) begin
      // no new request may be taken while busy
      check_bit({name, " req_rdy busy"}, 1'b0, req_rdy);
      @(posedge clk);
      #1;
      edges++;
      if (edges > MAX_WAIT) begin
        abort_on_hang("raised resp_val");
      end
    end
    check_latency({name, " latency"}, LATENCY, edges + 1);
    res = resp_result;
  endtask

  task automatic take_response();
    resp_rdy = 1'b1;
    @(posedge clk);
    #1;
    resp_rdy = 1'b0;
  endtask

  task automatic run_one(input string name, input div_pkg::div_fn_e fn,
                         input logic [W-1:0] a, input logic [W-1:0] b);
    int                   waits;
    div_pkg::div_result_t res;
    drive_request(fn, a, b);
    wait_accept(waits);
    wait_response(name, res);
    check_result(name, expected_div(fn, a, b), res);
    take_response();
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------

  task automatic test_reset_state();
    check_bit("reset req_rdy", 1'b1, req_rdy);
    check_bit("reset resp_val", 1'b0, resp_val);
  endtask

  task automatic test_unsigned();
    logic [W-1:0] a;
    logic [W-1:0] b;
    run_one("udiv 100/7", div_pkg::DIV_FN_UNSIGNED, 32'd100, 32'd7);
    run_one("udiv big/16", div_pkg::DIV_FN_UNSIGNED, 32'hFFFF_FFFF, 32'h10);
    run_one("udiv equal", div_pkg::DIV_FN_UNSIGNED, 32'd12345678, 32'd12345678);
    run_one("udiv msb/3", div_pkg::DIV_FN_UNSIGNED, 32'h8000_0000, 32'd3);
    run_one("udiv mixed", div_pkg::DIV_FN_UNSIGNED, 32'hDEAD_BEEF, 32'h1234);
    for (int i = 0; i < 20; i++) begin
      a = $urandom;
      // spread divisor sizes across the whole range
      b = $urandom >> ($urandom % W);
      run_one($sformatf("udiv rand %0d", i), div_pkg::DIV_FN_UNSIGNED, a, b);
    end
  endtask

  task automatic test_signed();
    logic [W-1:0] a;
    logic [W-1:0] b;
    run_one("sdiv -/+", div_pkg::DIV_FN_SIGNED, -32'sd100, 32'sd7);
    run_one("sdiv +/-", div_pkg::DIV_FN_SIGNED, 32'sd100, -32'sd7);
    run_one("sdiv -/-", div_pkg::DIV_FN_SIGNED, -32'sd100, -32'sd7);
    run_one("sdiv +/+", div_pkg::DIV_FN_SIGNED, 32'sd100, 32'sd7);
    for (int i = 0; i < 12; i++) begin
      a = $urandom;
      b = $urandom >> ($urandom % W);
      // make sure negative divisors show up too
      if (i % 2 == 1) begin
        b = -b;
      end
      run_one($sformatf("sdiv rand %0d", i), div_pkg::DIV_FN_SIGNED, a, b);
    end
  endtask

  task automatic test_corners();
    run_one("udiv by zero", div_pkg::DIV_FN_UNSIGNED, 32'd1234, 32'd0);
    run_one("sdiv - by zero", div_pkg::DIV_FN_SIGNED, -32'sd1234, 32'd0);
    run_one("sdiv + by zero", div_pkg::DIV_FN_SIGNED, 32'sd1234, 32'd0);
    run_one("sdiv overflow", div_pkg::DIV_FN_SIGNED, 32'h8000_0000, 32'hFFFF_FFFF);
    run_one("udiv small/big", div_pkg::DIV_FN_UNSIGNED, 32'd5, 32'd9);
    run_one("udiv by one", div_pkg::DIV_FN_UNSIGNED, 32'hCAFE_F00D, 32'd1);
  endtask

  task automatic test_backpressure();
    div_pkg::div_fn_e     fn;
    logic [W-1:0]         a;
    logic [W-1:0]         b;
    int                   waits;
    int                   stall;
    string                name;
    div_pkg::div_result_t held;
    for (int i = 0; i < 5; i++) begin
      fn   = div_pkg::div_fn_e'($urandom % 2);
      a    = $urandom;
      b    = $urandom >> ($urandom % W);
      name = $sformatf("stall %0d", i);
      drive_request(fn, a, b);
      wait_accept(waits);
      wait_response(name, held);
      check_result(name, expected_div(fn, a, b), held);
      stall = 1 + ($urandom % 10);
      // response must freeze while the consumer is not ready
      repeat (stall) begin
        @(posedge clk);
        #1;
        check_bit({name, " resp_val"}, 1'b1, resp_val);
        check_result({name, " held"}, held, resp_result);
        check_bit({name, " req_rdy"}, 1'b0, req_rdy);
      end
      take_response();
      check_bit({name, " req_rdy after"}, 1'b1, req_rdy);
    end
  endtask

  task automatic test_back_to_back();
    logic [W-1:0]         a_list [4];
    logic [W-1:0]         b_list [4];
    int                   waits;
    string                name;
    div_pkg::div_result_t res;
    a_list = '{32'd1000, -32'sd999, 32'hFFFF_0000, 32'd77};
    b_list = '{32'd33, 32'sd10, 32'h0000_0101, 32'd0};
    drive_request(div_pkg::DIV_FN_SIGNED, a_list[0], b_list[0]);
    wait_accept(waits);
    for (int i = 0; i < 4; i++) begin
      name = $sformatf("b2b %0d", i);
      wait_response(name, res);
      check_result(name, expected_div(div_pkg::DIV_FN_SIGNED, a_list[i], b_list[i]), res);
      if (i < 3) begin
        // next request already waiting when the response is taken
        drive_request(div_pkg::DIV_FN_SIGNED, a_list[i+1], b_list[i+1]);
        take_response();
        wait_accept(waits);
        check_latency({name, " accept gap"}, 1, waits + 1);
      end else begin
        take_response();
      end
    end
  endtask

  // --------------------------------------------------
  // watchdog and main sequence
  // --------------------------------------------------

  initial begin
    #((NUM_REQS + 10) * 40 * 4);
    $display("timeout: the tests did not finish in the allowed time");
    $display("TB FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    req_fn   = div_pkg::DIV_FN_UNSIGNED;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    // one seed for the whole run
    void'($urandom(36));
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    test_reset_state();
    test_unsigned();
    test_signed();
    test_corners();
    test_backpressure();
    test_back_to_back();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== int_div_iterative.sv ====
// iterative integer divider, top level
// joins the shift-subtract datapath and its controller
`default_nettype none

`include "div_consts.svh"

module int_div_iterative (
  input  wire                   clk,
  input  wire                   reset,

  // request: function and two operands
  input  wire div_pkg::div_fn_e req_fn,
  input  wire [`DIV_DATA_W-1:0] req_a,
  input  wire [`DIV_DATA_W-1:0] req_b,
  input  wire                   req_val,
  output logic                  req_rdy,

  // response: {remainder, quotient}
  output div_pkg::div_result_t  resp_result,
  output logic                  resp_val,
  input  wire                   resp_rdy
);

  // controller to datapath
  logic a_en;
  logic b_en;
  logic a_mux_sel;

  // payload path
  int_div_dpath dpath (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .a_en        (a_en),
    .b_en        (b_en),
    .a_mux_sel   (a_mux_sel),
    .resp_result (resp_result)
  );

  // handshakes and sequencing
  int_div_ctrl ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .resp_val  (resp_val),
    .resp_rdy  (resp_rdy),
    .a_en      (a_en),
    .b_en      (b_en),
    .a_mux_sel (a_mux_sel)
  );

  // ------------------------------------------------
  // response stability under back-pressure
  // ------------------------------------------------

  // a stalled response must not change until the consumer takes it
  resp_stable_when_stalled: assert property (
    @(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> $stable(resp_result)
  );

endmodule

`default_nettype wire

// ==== int_div_ctrl.sv ====
// integer divider controller
// idle/calc/done FSM with iteration counter, handshakes and datapath enables
`default_nettype none

`include "div_consts.svh"

module int_div_ctrl (
  input  wire  clk,
  input  wire  reset,

  // request handshake
  input  wire  req_val,
  output logic req_rdy,

  // response handshake
  output logic resp_val,
  input  wire  resp_rdy,

  // datapath enables
  output logic a_en,
  output logic b_en,
  output logic a_mux_sel
);

  localparam int COUNT_W = `DIV_COUNT_W;

  // last count value seen in CALC
  localparam logic [COUNT_W-1:0] LAST_ITER = COUNT_W'(`DIV_ITERS - 1);

  div_pkg::div_state_e state;
  div_pkg::div_state_e state_next;
  logic [COUNT_W-1:0]  count;

  logic req_go;
  logic resp_go;
  logic last_iter;

  // ------------------------------------------------
  // handshake decode
  // ------------------------------------------------

  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  assign last_iter = (count == LAST_ITER);

  // ------------------------------------------------
  // next state
  // ------------------------------------------------

  always_comb begin
    state_next = state;
    unique case (state)
      div_pkg::DIV_IDLE: begin
        if (req_go) begin
          state_next = div_pkg::DIV_CALC;
        end
      end
      div_pkg::DIV_CALC: begin
        // leave after the final shift-subtract
        if (last_iter) begin
          state_next = div_pkg::DIV_DONE;
        end
      end
      div_pkg::DIV_DONE: begin
        // back-pressure keeps us here
        if (resp_go) begin
          state_next = div_pkg::DIV_IDLE;
        end
      end
      default: begin
        state_next = div_pkg::DIV_IDLE;
      end
    endcase
  end

  // ------------------------------------------------
  // state and counter registers
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= div_pkg::DIV_IDLE;
      count <= '0;
    end else begin
      state <= state_next;
      // counter restarts on accept, steps once per iteration
      if (req_go) begin
        count <= '0;
      end else if (state == div_pkg::DIV_CALC) begin
        count <= count + 1'b1;
      end
    end
  end

  // ------------------------------------------------
  // outputs, decoded from state
  // ------------------------------------------------

  always_comb begin
    req_rdy   = (state == div_pkg::DIV_IDLE);
    resp_val  = (state == div_pkg::DIV_DONE);
    // operands and initial remainder load on the accepting edge
    b_en      = req_go;
    a_en      = req_go || (state == div_pkg::DIV_CALC);
    a_mux_sel = (state == div_pkg::DIV_CALC);
  end

  // ------------------------------------------------
  // checks
  // ------------------------------------------------

  // one division in flight, so both sides never offer at once
  rdy_val_exclusive: assert property (
    @(posedge clk) disable iff (reset)
    !(req_rdy && resp_val)
  );

  counter_in_range: assert property (
    @(posedge clk) disable iff (reset)
    (state == div_pkg::DIV_CALC) |-> (count < COUNT_W'(`DIV_ITERS))
  );

  // accept edge, then one edge per iteration, then the response shows
  fixed_latency: assert property (
    @(posedge clk) disable iff (reset)
    req_go |-> ##(`DIV_ITERS + 1) resp_val
  );

endmodule

`default_nettype wire

// ==== int_div_dpath.sv ====
// integer divider datapath
// restoring shift-subtract on a 65-bit remainder/quotient register,
// with operand magnitude conversion and final sign correction
`default_nettype none

`include "div_consts.svh"

module int_div_dpath (
  input  wire                   clk,
  input  wire                   reset,

  // request payload
  input  wire div_pkg::div_fn_e req_fn,
  input  wire [`DIV_DATA_W-1:0] req_a,
  input  wire [`DIV_DATA_W-1:0] req_b,

  // enables from the controller
  input  wire                   a_en,
  input  wire                   b_en,
  input  wire                   a_mux_sel,

  // response payload
  output div_pkg::div_result_t  resp_result
);

  localparam int W = `DIV_DATA_W;

  // two's complement negate when neg is set
  function automatic logic [W-1:0] cond_neg(
    input logic         neg,
    input logic [W-1:0] val
  );
    logic [W-1:0] res;
    res = neg ? (~val + 1'b1) : val;
    return res;
  endfunction

  // ------------------------------------------------
  // request side: operand magnitudes
  // ------------------------------------------------

  logic         req_signed;
  logic [W-1:0] mag_a;
  logic [W-1:0] mag_b;

  assign req_signed = (req_fn == div_pkg::DIV_FN_SIGNED);

  // unsigned requests pass straight through
  // most negative value maps onto 0x80000000, which is right as unsigned
  assign mag_a = cond_neg(req_signed && req_a[W-1], req_a);
  assign mag_b = cond_neg(req_signed && req_b[W-1], req_b);

  // ------------------------------------------------
  // operand registers
  // ------------------------------------------------

  div_pkg::div_fn_e fn_reg;
  logic             sign_a_reg;
  logic             sign_b_reg;

  // divisor magnitude, held for the whole loop
  logic [W-1:0]     b_reg;

  // loaded together with a_reg on the accepting edge
  always_ff @(posedge clk) begin
    if (b_en) begin
      fn_reg     <= req_fn;
      sign_a_reg <= req_a[W-1];
      sign_b_reg <= req_b[W-1];
      b_reg      <= mag_b;
    end
  end

  // ------------------------------------------------
  // remainder/quotient register and one loop step
  // ------------------------------------------------

  // [2W:W]   working remainder, one guard bit on top
  // [W-1:0]  dividend bits moving out, quotient bits moving in
  logic [2*W:0]   a_reg;
  logic [2*W:0]   a_init;
  logic [2*W:0]   a_step;
  logic [2*W:0]   a_next;

  // trial difference, two bits above the word for the sign
  logic [W+1:0]   trial;
  logic           trial_neg;

  // start with a zero remainder and the dividend magnitude below it
  assign a_init = {{(W+1){1'b0}}, mag_a};

  // shifted remainder is a_reg[2W:W-1], subtract the divisor from it
  assign trial     = a_reg[2*W:W-1] - {2'b00, b_reg};
  assign trial_neg = trial[W+1];

  // non-negative difference: keep it and shift in a one
  // negative difference: keep the shifted value, quotient bit zero
  always_comb begin
    if (trial_neg) begin
      a_step = {a_reg[2*W-1:0], 1'b0};
    end else begin
      a_step = {trial[W:0], a_reg[W-2:0], 1'b1};
    end
  end

  // load vs iterate
  assign a_next = a_mux_sel ? a_step : a_init;

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_next;
    end
  end

  // ------------------------------------------------
  // result with sign correction
  // ------------------------------------------------

  logic         res_signed;
  logic         neg_quot;
  logic         neg_rem;
  logic [W-1:0] quot_mag;
  logic [W-1:0] rem_mag;
  logic [W-1:0] quot_out;
  logic [W-1:0] rem_out;

  assign res_signed = (fn_reg == div_pkg::DIV_FN_SIGNED);

  // quotient negative when exactly one operand was
  assign neg_quot = res_signed && (sign_a_reg ^ sign_b_reg);

  // remainder follows the dividend
  assign neg_rem  = res_signed && sign_a_reg;

  // guard bit is always clear once the loop is done
  assign quot_mag = a_reg[W-1:0];
  assign rem_mag  = a_reg[2*W-1:W];

  assign quot_out = cond_neg(neg_quot, quot_mag);
  assign rem_out  = cond_neg(neg_rem, rem_mag);

  // combinational from the registers, valid only in DONE
  assign resp_result = {rem_out, quot_out};

  // ------------------------------------------------
  // checks
  // ------------------------------------------------

  // controller must never iterate on the same edge that loads operands,
  // or the step would run against a stale divisor
  a_sel_not_with_load: assert property (
    @(posedge clk) disable iff (reset)
    !(a_mux_sel && b_en)
  );

endmodule

`default_nettype wire

// ==== div_pkg.sv ====
// integer divider package
// function and state encodings plus the response payload type
`default_nettype none

`include "div_consts.svh"

package div_pkg;

  // request function bit
  typedef enum logic {
    DIV_FN_UNSIGNED = 1'b0,
    DIV_FN_SIGNED   = 1'b1
  } div_fn_e;

  // controller states
  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_CALC = 2'd1,
    DIV_DONE = 2'd2
  } div_state_e;

  // response payload
  // remainder in the upper word, quotient in the lower word
  typedef struct packed {
    logic [`DIV_DATA_W-1:0] rem;
    logic [`DIV_DATA_W-1:0] quot;
  } div_result_t;

endpackage

`default_nettype wire

// ==== div_consts.svh ====
// integer divider constants
// widths and loop length shared by the package and the RTL

`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// ------------------------------------------------
// operand and loop sizing
// ------------------------------------------------

// one operand word
`define DIV_DATA_W 32

// one quotient bit per step
`define DIV_ITERS 32

// iteration counter, wide enough for DIV_ITERS
`define DIV_COUNT_W 6

`endif
